//--- Makefile
# Verilator build and run for the ROB testbench

VERILATOR ?= verilator
TOP       ?= tb_rob
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation did not finish, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- filelist.f
rob_pkg.sv
rob_fifo_ram.sv
rob_completion.sv
rob_retire.sv
rob_csr.sv
rob_top.sv
rob_assertions.sv
tb_rob.sv

//--- rob_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module rob_assertions
    import rob_pkg::*;
#(
    parameter  int unsigned N_ENTRIES  = 8,
    parameter  int unsigned N_WB_PORTS = 2,
    localparam int unsigned PTR_W      = $clog2(N_ENTRIES),
    localparam int unsigned CTR_W      = PTR_W + 1
) (
    input  logic                              clk,
    input  logic                              rst_aL,
    input  logic                              ack,
    input  logic                              disp_valid,
    input  logic                              disp_ready,
    input  logic [CTR_W-1:0]                  count,
    input  logic                              retire_valid,
    input  rob_wb_t [N_WB_PORTS-1:0]          wb_req,
    input  logic [N_WB_PORTS-1:0][PTR_W-1:0]  wb_tag
);

    int   fail_cnt = 0;  // read by the testbench
    logic tag_clash;
    logic enq_fire;

    assign enq_fire = disp_valid && disp_ready;

    always_comb begin
        tag_clash = 1'b0;
        for (int i = 0; i < N_WB_PORTS; i++) begin
            for (int j = i + 1; j < N_WB_PORTS; j++) begin
                if (wb_req[i].valid && wb_req[j].valid && (wb_tag[i] == wb_tag[j])) begin
                    tag_clash = 1'b1;
                end
            end
        end
    end

    ack_single: assert property (@(posedge clk) disable iff (!rst_aL) ack |=> !ack)
        else begin fail_cnt++; $error("bus ack held high for two cycles"); end

    // full judged from occupancy, not from the wrap bits
    ready_vs_full: assert property (@(posedge clk) disable iff (!rst_aL)
        disp_ready == (count != CTR_W'(N_ENTRIES)))
        else begin fail_cnt++; $error("disp_ready does not follow occupancy"); end

    // a report needs a real dequeue, occupancy drops by one net of the dispatch
    retire_after_pop: assert property (@(posedge clk) disable iff (!rst_aL)
        retire_valid |-> count == $past(count) + $past(enq_fire) - 1'b1)
        else begin fail_cnt++; $error("retire report without a pop"); end

    wb_tags_differ: assert property (@(posedge clk) disable iff (!rst_aL) !tag_clash)
        else begin fail_cnt++; $error("two writeback ports carry the same tag"); end

endmodule

bind rob_top rob_assertions #(
    .N_ENTRIES  (N_ENTRIES),
    .N_WB_PORTS (N_WB_PORTS)
) u_assertions (
    .clk          (clk),
    .rst_aL       (rst_aL),
    .ack          (bus_rsp.ack),
    .disp_valid   (disp_valid),
    .disp_ready   (disp_ready),
    .count        (count),
    .retire_valid (retire.valid),
    .wb_req       (wb_req),
    .wb_tag       (wb_tag)
);

`default_nettype wire

//--- rob_completion.sv
`timescale 1ns/1ns
`default_nettype none

module rob_completion
    import rob_pkg::*;
#(
    parameter  int unsigned N_ENTRIES  = 8,
    parameter  int unsigned N_WB_PORTS = 2,
    localparam int unsigned PTR_W      = $clog2(N_ENTRIES)
) (
    input  rob_wb_t [N_WB_PORTS-1:0]              wb_req,
    input  logic [N_WB_PORTS-1:0][PTR_W-1:0]      wb_tag,
    input  logic [N_ENTRIES-1:0][ENTRY_W-1:0]     entry_douts,

    output logic [N_WB_PORTS-1:0]                 wr_en,
    output logic [N_WB_PORTS-1:0][PTR_W-1:0]      wr_addr,
    output logic [N_WB_PORTS-1:0][ENTRY_W-1:0]    wr_data
);

    // entry as it sits in the store, and as it goes back
    rob_entry_t [N_WB_PORTS-1:0] cur_entry;
    rob_entry_t [N_WB_PORTS-1:0] upd_entry;

    // read-modify-write per port
    // dest and pc pass through untouched, only the status bits change
    always_comb begin
        for (int i = 0; i < N_WB_PORTS; i++) begin
            cur_entry[i] = rob_entry_t'(entry_douts[wb_tag[i]]);

            upd_entry[i]      = cur_entry[i];
            upd_entry[i].done = 1'b1;
            // exceptions accumulate, a clean writeback never clears one
            upd_entry[i].exc  = cur_entry[i].exc | wb_req[i].exc;
        end
    end

    always_comb begin
        for (int i = 0; i < N_WB_PORTS; i++) begin
            wr_en[i]   = wb_req[i].valid;
            wr_addr[i] = wb_tag[i];
            wr_data[i] = upd_entry[i];
        end
    end

endmodule

`default_nettype wire

//--- rob_csr.sv
`timescale 1ns/1ns
`default_nettype none

module rob_csr
    import rob_pkg::*;
#(
    parameter  int unsigned N_ENTRIES = 8,
    localparam int unsigned CTR_W     = $clog2(N_ENTRIES) + 1
) (
    input  logic              clk,
    input  logic              rst_aL,

    input  wb_req_t           bus_req,
    output wb_rsp_t           bus_rsp,

    input  logic [CTR_W-1:0]  count,
    input  logic              full,
    input  logic              empty,
    input  rob_retire_t       retire,

    output logic              retire_en,
    output logic              flush
);

    logic        ack_q;
    logic [31:0] rdat_q;
    logic [31:0] rdat;
    logic [31:0] retired_cnt_q;
    logic [31:0] exc_cnt_q;
    logic        acc;      // access accepted on this edge
    logic        wr_acc;
    rob_reg_e    reg_sel;

    // ack low in between, so a held stb gets every other cycle
    assign acc     = bus_req.cyc && bus_req.stb && !ack_q;
    assign wr_acc  = acc && bus_req.we;
    assign reg_sel = rob_reg_e'(bus_req.adr);

    always_comb begin
        rdat = '0;
        case (reg_sel)
            REG_CTRL:    rdat[0] = retire_en;  // flush bit reads 0
            REG_STATUS: begin
                rdat[7:0] = 8'(count);
                rdat[8]   = empty;
                rdat[9]   = full;
            end
            REG_RETIRED: rdat = retired_cnt_q;
            REG_EXC:     rdat = exc_cnt_q;
            default:     rdat = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_aL) begin
        if (!rst_aL) begin
            ack_q     <= 1'b0;
            retire_en <= 1'b0;
            flush     <= 1'b0;
        end else begin
            ack_q <= acc;
            flush <= wr_acc && (reg_sel == REG_CTRL) && bus_req.dat[1];  // one-cycle pulse
            if (wr_acc && (reg_sel == REG_CTRL)) begin
                retire_en <= bus_req.dat[0];
            end
        end
    end

    // read data sampled on the edge that raises ack
    always_ff @(posedge clk) begin
        if (acc && !bus_req.we) begin
            rdat_q <= rdat;
        end
    end

    always_ff @(posedge clk or negedge rst_aL) begin
        if (!rst_aL) begin
            retired_cnt_q <= '0;
            exc_cnt_q     <= '0;
        end else if (retire.valid) begin
            retired_cnt_q <= retired_cnt_q + 1'b1;
            if (retire.exc) begin
                exc_cnt_q <= exc_cnt_q + 1'b1;
            end
        end
    end

    assign bus_rsp = '{ack: ack_q, dat: rdat_q};

endmodule

`default_nettype wire

//--- rob_fifo_ram.sv
`timescale 1ns/1ns
`default_nettype none

module rob_fifo_ram
    import rob_pkg::*;
#(
    parameter  int unsigned N_ENTRIES  = 8,
    parameter  int unsigned N_WB_PORTS = 2,
    localparam int unsigned PTR_W      = $clog2(N_ENTRIES),
    localparam int unsigned CTR_W      = PTR_W + 1
) (
    input  logic                                  clk,
    input  logic                                  rst_aL,
    input  logic                                  flush,

    input  logic                                  enq_valid,
    input  rob_entry_t                            enq_data,
    output logic                                  enq_ready,
    output logic [PTR_W-1:0]                      enq_addr,   // tail tag

    input  logic                                  deq_ready,
    output logic                                  deq_valid,
    output rob_entry_t                            deq_data,
    output logic [PTR_W-1:0]                      deq_addr,   // head tag

    input  logic [N_WB_PORTS-1:0]                 wr_en,
    input  logic [N_WB_PORTS-1:0][PTR_W-1:0]      wr_addr,
    input  logic [N_WB_PORTS-1:0][ENTRY_W-1:0]    wr_data,
    output logic [N_ENTRIES-1:0][ENTRY_W-1:0]     entry_douts,

    output logic [CTR_W-1:0]                      count,
    output logic                                  full,
    output logic                                  empty
);

    // counters carry one extra wrap bit above the pointer
    logic [CTR_W-1:0]                  enq_ctr_q;
    logic [CTR_W-1:0]                  deq_ctr_q;
    logic [N_ENTRIES-1:0][ENTRY_W-1:0] mem_q;

    logic [CTR_W-1:0]                  enq_ctr_d;
    logic [CTR_W-1:0]                  deq_ctr_d;
    logic [N_ENTRIES-1:0][ENTRY_W-1:0] mem_d;

    logic [PTR_W-1:0]                  enq_ptr;
    logic [PTR_W-1:0]                  deq_ptr;
    logic                              do_enq;
    logic                              do_deq;

    assign enq_ptr = enq_ctr_q[PTR_W-1:0];
    assign deq_ptr = deq_ctr_q[PTR_W-1:0];

    assign empty = (enq_ctr_q == deq_ctr_q);
    // same slot, opposite lap
    assign full  = (enq_ctr_q[PTR_W] != deq_ctr_q[PTR_W]) && (enq_ptr == deq_ptr);
    assign count = enq_ctr_q - deq_ctr_q;

    assign enq_ready   = !full;
    assign enq_addr    = enq_ptr;
    assign deq_valid   = !empty;
    assign deq_addr    = deq_ptr;
    assign deq_data    = rob_entry_t'(mem_q[deq_ptr]);
    assign entry_douts = mem_q;

    assign do_enq = enq_valid && enq_ready;
    assign do_deq = deq_valid && deq_ready;

    assign enq_ctr_d = do_enq ? enq_ctr_q + 1'b1 : enq_ctr_q;
    assign deq_ctr_d = do_deq ? deq_ctr_q + 1'b1 : deq_ctr_q;

    always_comb begin
        mem_d = mem_q;
        if (do_enq) begin
            mem_d[enq_ptr] = enq_data;
        end
        // ports target distinct live entries, never the free tail slot
        for (int i = 0; i < N_WB_PORTS; i++) begin
            if (wr_en[i]) begin
                mem_d[wr_addr[i]] = wr_data[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_aL) begin
        if (!rst_aL) begin
            enq_ctr_q <= '0;
            deq_ctr_q <= '0;
            mem_q     <= '0;
        end else if (flush) begin  // wins over enqueue and writeback
            enq_ctr_q <= '0;
            deq_ctr_q <= '0;
            mem_q     <= '0;
        end else begin
            enq_ctr_q <= enq_ctr_d;
            deq_ctr_q <= deq_ctr_d;
            mem_q     <= mem_d;
        end
    end

endmodule

`default_nettype wire

//--- rob_pkg.sv
`default_nettype none

package rob_pkg;

    // payload handed over at dispatch
    typedef struct packed {
        logic [4:0]  dest;  // architectural destination register
        logic [15:0] pc;    // low half of the program counter
    } rob_disp_t;

    // one slot of the reorder buffer
    typedef struct packed {
        logic [4:0]  dest;
        logic [15:0] pc;
        logic        done;  // result written back
        logic        exc;   // writeback raised an exception
    } rob_entry_t;

    localparam int unsigned ENTRY_W = $bits(rob_entry_t);

    // writeback request, tag travels on its own port
    typedef struct packed {
        logic valid;
        logic exc;
    } rob_wb_t;

    // report of the entry retired in the previous cycle
    typedef struct packed {
        logic        valid;
        logic [4:0]  dest;
        logic [15:0] pc;
        logic        exc;
    } rob_retire_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;  // word address
        logic [31:0] dat;
    } wb_req_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef enum logic [3:0] {
        REG_CTRL    = 4'd0,  // bit0 retire_en, bit1 flush
        REG_STATUS  = 4'd1,  // count, empty, full
        REG_RETIRED = 4'd2,
        REG_EXC     = 4'd3
    } rob_reg_e;

    // stimulus ops of the testbench table
    typedef enum logic [2:0] {
        OP_DISP,
        OP_WB,
        OP_REG_WR,
        OP_REG_RD,
        OP_IDLE
    } tb_op_e;

endpackage

`default_nettype wire

//--- rob_retire.sv
`timescale 1ns/1ns
`default_nettype none

module rob_retire
    import rob_pkg::*;
(
    input  logic        clk,
    input  logic        rst_aL,
    input  logic        flush,
    input  logic        retire_en,

    input  logic        deq_valid,
    input  rob_entry_t  deq_data,
    output logic        deq_ready,

    output rob_retire_t retire
);

    logic        pop;
    logic        valid_q;
    logic [4:0]  dest_q;
    logic [15:0] pc_q;
    logic        exc_q;

    // head leaves only once complete, strictly in order
    assign deq_ready = retire_en && deq_data.done;

    // a flush clears the store on the same edge, so nothing is popped
    assign pop = deq_valid && deq_ready && !flush;

    always_ff @(posedge clk or negedge rst_aL) begin
        if (!rst_aL) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pop;  // one cycle per popped entry
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dest_q <= deq_data.dest;
            pc_q   <= deq_data.pc;
            exc_q  <= deq_data.exc;
        end
    end

    assign retire = '{valid: valid_q, dest: dest_q, pc: pc_q, exc: exc_q};

endmodule

`default_nettype wire

//--- rob_top.sv
`timescale 1ns/1ns
`default_nettype none

module rob_top
    import rob_pkg::*;
#(
    parameter  int unsigned N_ENTRIES  = 8,
    parameter  int unsigned N_WB_PORTS = 2,
    localparam int unsigned PTR_W      = $clog2(N_ENTRIES),
    localparam int unsigned CTR_W      = PTR_W + 1
) (
    input  logic                              clk,
    input  logic                              rst_aL,

    input  logic                              disp_valid,
    input  rob_disp_t                         disp,
    output logic                              disp_ready,
    output logic [PTR_W-1:0]                  disp_tag,

    input  rob_wb_t [N_WB_PORTS-1:0]          wb_req,
    input  logic [N_WB_PORTS-1:0][PTR_W-1:0]  wb_tag,

    output rob_retire_t                       retire,

    input  wb_req_t                           bus_req,
    output wb_rsp_t                           bus_rsp
);

    rob_entry_t                         enq_data;
    rob_entry_t                         deq_data;
    logic                               deq_valid;
    logic                               deq_ready;
    logic [N_WB_PORTS-1:0]              wr_en;
    logic [N_WB_PORTS-1:0][PTR_W-1:0]   wr_addr;
    logic [N_WB_PORTS-1:0][ENTRY_W-1:0] wr_data;
    logic [N_ENTRIES-1:0][ENTRY_W-1:0]  entry_douts;
    logic [CTR_W-1:0]                   count;
    logic                               full;
    logic                               empty;
    logic                               retire_en;
    logic                               flush;

    // new entries start incomplete
    assign enq_data = '{dest: disp.dest, pc: disp.pc, done: 1'b0, exc: 1'b0};

    rob_fifo_ram #(
        .N_ENTRIES  (N_ENTRIES),
        .N_WB_PORTS (N_WB_PORTS)
    ) u_fifo (
        .clk         (clk),
        .rst_aL      (rst_aL),
        .flush       (flush),
        .enq_valid   (disp_valid),
        .enq_data    (enq_data),
        .enq_ready   (disp_ready),
        .enq_addr    (disp_tag),
        .deq_ready   (deq_ready),
        .deq_valid   (deq_valid),
        .deq_data    (deq_data),
        .deq_addr    (),           // head tag has no consumer here
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .entry_douts (entry_douts),
        .count       (count),
        .full        (full),
        .empty       (empty)
    );

    rob_completion #(
        .N_ENTRIES  (N_ENTRIES),
        .N_WB_PORTS (N_WB_PORTS)
    ) u_completion (
        .wb_req      (wb_req),
        .wb_tag      (wb_tag),
        .entry_douts (entry_douts),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    rob_retire u_retire (
        .clk       (clk),
        .rst_aL    (rst_aL),
        .flush     (flush),
        .retire_en (retire_en),
        .deq_valid (deq_valid),
        .deq_data  (deq_data),
        .deq_ready (deq_ready),
        .retire    (retire)
    );

    rob_csr #(
        .N_ENTRIES (N_ENTRIES)
    ) u_csr (
        .clk       (clk),
        .rst_aL    (rst_aL),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .count     (count),
        .full      (full),
        .empty     (empty),
        .retire    (retire),
        .retire_en (retire_en),
        .flush     (flush)
    );

endmodule

`default_nettype wire

//--- tb_rob.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rob
    import rob_pkg::*;
();

    localparam int unsigned N_ENTRIES  = 8;
    localparam int unsigned N_WB_PORTS = 2;
    localparam int unsigned PTR_W      = $clog2(N_ENTRIES);
    localparam int          CLK_PERIOD = 20;
    localparam int          DRIVE_DLY  = 2;
    localparam int          TIMEOUT    = 50;            // cycles per wait
    localparam logic [31:0] ANY        = 32'hFFFF_FFFF; // no literal expectation

    typedef struct packed {
        tb_op_e      op;
        logic [31:0] a;    // tag, register address or idle cycles
        logic [31:0] d;    // wb: bit0 exc0, bit4 port1 valid, bit5 exc1, bits 10:8 tag1
        logic [31:0] exp;
    } row_t;

    typedef struct packed {
        logic [PTR_W-1:0] tag;
        logic [4:0]       dest;
        logic [15:0]      pc;
        logic             done;
        logic             exc;
    } model_t;

    logic                             clk;
    logic                             rst_aL;
    logic                             disp_valid;
    rob_disp_t                        disp;
    logic                             disp_ready;
    logic [PTR_W-1:0]                 disp_tag;
    rob_wb_t [N_WB_PORTS-1:0]         wb_req;
    logic [N_WB_PORTS-1:0][PTR_W-1:0] wb_tag;
    rob_retire_t                      retire;
    wb_req_t                          bus_req;
    wb_rsp_t                          bus_rsp;

    row_t             rows[$];
    model_t           model_q[$];  // live entries, head first
    int               seed;
    int               retired_cnt;
    int               exc_cnt;
    logic [PTR_W-1:0] tail_tag;
    logic             model_retire_en;

    rob_top #(
        .N_ENTRIES  (N_ENTRIES),
        .N_WB_PORTS (N_WB_PORTS)
    ) DUT (
        .clk        (clk),
        .rst_aL     (rst_aL),
        .disp_valid (disp_valid),
        .disp       (disp),
        .disp_ready (disp_ready),
        .disp_tag   (disp_tag),
        .wb_req     (wb_req),
        .wb_tag     (wb_tag),
        .retire     (retire),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] expv, input string what);
        if (got !== expv) begin
            $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, expv);
            abort_run();
        end
    endtask

    task automatic add_row(input tb_op_e op, input logic [31:0] a, input logic [31:0] d,
                           input logic [31:0] expv);
        rows.push_back('{op: op, a: a, d: d, exp: expv});
    endtask

    // retire reports must follow the head of the model, one per cycle
    always @(negedge clk) begin
        model_t head;
        if (rst_aL && retire.valid) begin
            if (model_q.size() == 0) begin
                $display("retire report at %0t ns with no entry left in the model", $time);
                abort_run();
            end
            head = model_q.pop_front();
            check_eq(head.done, 1'b1, "retired entry was not complete");
            check_eq(retire.dest, head.dest, "retire dest");
            check_eq(retire.pc, head.pc, "retire pc");
            check_eq(retire.exc, head.exc, "retire exc");
            retired_cnt++;
            if (head.exc) exc_cnt++;
        end
    end

    // a bound assertion that fired ends the run at once
    always @(negedge clk) begin
        if (DUT.u_assertions.fail_cnt != 0) begin
            $display("a concurrent assertion on the DUT failed at %0t ns", $time);
            abort_run();
        end
    end

    task automatic dispatch_one(input logic [31:0] exp_tag);
        logic [31:0] r;
        logic        accepted;
        if (model_q.size() < N_ENTRIES) begin
            check_eq(disp_ready, 1'b1, "disp_ready with free slots");
            check_eq(disp_tag, tail_tag, "disp_tag against model");
            if (exp_tag != ANY) check_eq(disp_tag, exp_tag, "disp_tag against table");
        end else if (!model_retire_en) begin
            check_eq(disp_ready, 1'b0, "disp_ready while full");
        end
        r = $random(seed);
        disp.dest  = r[4:0];
        disp.pc    = r[31:16];
        disp_valid = 1'b1;
        accepted   = disp_ready;  // stable until the next edge
        @(posedge clk);
        #DRIVE_DLY;
        disp_valid = 1'b0;
        if (accepted) begin
            model_q.push_back('{tag: tail_tag, dest: r[4:0], pc: r[31:16], done: 1'b0, exc: 1'b0});
            tail_tag++;  // wraps with the pointer
        end
    endtask

    task automatic mark_done(input logic [PTR_W-1:0] tag, input logic exc);
        model_t ent;
        bit     found;
        found = 0;
        foreach (model_q[i]) begin
            if (model_q[i].tag == tag) begin
                ent        = model_q[i];
                ent.done   = 1'b1;
                ent.exc    = ent.exc | exc;
                model_q[i] = ent;
                found      = 1;
            end
        end
        if (!found) begin
            $display("writeback to tag %0d which is not live in the model", tag);
            abort_run();
        end
    endtask

    task automatic writeback(input logic [31:0] a, input logic [31:0] d);
        wb_req           = '0;
        wb_tag           = '0;
        wb_req[0].valid  = 1'b1;
        wb_req[0].exc    = d[0];
        wb_tag[0]        = a[PTR_W-1:0];
        mark_done(a[PTR_W-1:0], d[0]);
        if (d[4]) begin  // second port in the same cycle
            wb_req[1].valid = 1'b1;
            wb_req[1].exc   = d[5];
            wb_tag[1]       = d[8 +: PTR_W];
            mark_done(d[8 +: PTR_W], d[5]);
        end
        @(posedge clk);
        #DRIVE_DLY;
        wb_req = '0;
        wb_tag = '0;
    endtask

    task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        int waited;
        bus_req.cyc = 1'b1;
        bus_req.stb = 1'b1;
        bus_req.we  = we;
        bus_req.adr = adr[3:0];
        bus_req.dat = wdat;
        waited      = 0;
        @(negedge clk);
        while (!bus_rsp.ack) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("no bus ack within %0d cycles at address %0d", TIMEOUT, adr);
                abort_run();
            end
            @(negedge clk);
        end
        rdat = bus_rsp.dat;
        @(posedge clk);
        #DRIVE_DLY;
        bus_req = '0;
    endtask

    task automatic reg_write(input logic [31:0] a, input logic [31:0] d);
        logic [31:0] unused;
        bus_access(1'b1, a, d, unused);
        if (rob_reg_e'(a[3:0]) == REG_CTRL) begin
            model_retire_en = d[0];
            if (d[1]) begin  // store already cleared on the edge after ack
                model_q.delete();
                tail_tag = '0;
            end
        end
    endtask

    task automatic reg_read(input logic [31:0] a, input logic [31:0] expv);
        logic [31:0] rdat;
        logic [31:0] model_val;
        int          n;
        n         = model_q.size();
        model_val = '0;
        case (rob_reg_e'(a[3:0]))
            REG_CTRL:    model_val[0] = model_retire_en;
            REG_STATUS: begin
                model_val[7:0] = 8'(n);
                model_val[8]   = (n == 0);
                model_val[9]   = (n == N_ENTRIES);
            end
            REG_RETIRED: model_val = retired_cnt;
            REG_EXC:     model_val = exc_cnt;
            default:     model_val = '0;
        endcase
        bus_access(1'b0, a, '0, rdat);
        check_eq(rdat, model_val, $sformatf("register %0d against model", a));
        if (expv != ANY) check_eq(rdat, expv, $sformatf("register %0d against table", a));
    endtask

    // wait for the model to see target retirements, then hold to catch extras
    task automatic wait_retired(input int target, input int idle);
        int waited;
        waited = 0;
        while (retired_cnt < target) begin
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
            if (waited > TIMEOUT) begin
                $display("only %0d of %0d entries retired in time", retired_cnt, target);
                abort_run();
            end
        end
        repeat (idle) @(posedge clk);
        #DRIVE_DLY;
        check_eq(retired_cnt, target, "retired count after idle window");
    endtask

    task automatic build_table();
        add_row(OP_REG_RD, REG_CTRL, 0, 0);
        add_row(OP_REG_RD, REG_RETIRED, 0, 0);
        add_row(OP_REG_RD, REG_EXC, 0, 0);
        for (int t = 0; t < N_ENTRIES; t++) add_row(OP_DISP, 0, 0, t);
        add_row(OP_DISP, 0, 0, ANY);                 // refused, ROB full
        add_row(OP_REG_RD, REG_STATUS, 0, 32'h208);
        add_row(OP_REG_WR, REG_CTRL, 32'h1, 0);      // out of order completion
        add_row(OP_WB, 3, 0, 0);
        add_row(OP_WB, 0, 0, 0);
        add_row(OP_WB, 1, 0, 0);
        add_row(OP_IDLE, 4, 0, 2);
        add_row(OP_WB, 2, 0, 0);
        add_row(OP_IDLE, 4, 0, 4);
        add_row(OP_WB, 4, 32'h510, 0);               // both ports, tags 4 and 5
        add_row(OP_IDLE, 2, 0, 6);
        add_row(OP_WB, 6, 32'h1, 0);                 // exception
        add_row(OP_WB, 7, 0, 0);
        add_row(OP_IDLE, 2, 0, 8);
        add_row(OP_REG_RD, REG_RETIRED, 0, 8);
        add_row(OP_REG_RD, REG_EXC, 0, 1);
        for (int t = 0; t < 3; t++) add_row(OP_DISP, 0, 0, t);
        add_row(OP_REG_WR, REG_CTRL, 32'h3, 0);      // flush, keep retire_en
        add_row(OP_REG_RD, REG_STATUS, 0, 32'h100);
        add_row(OP_REG_RD, REG_CTRL, 0, 1);
        add_row(OP_DISP, 0, 0, 0);
        add_row(OP_REG_WR, REG_CTRL, 32'h0, 0);      // hold completed entries
        add_row(OP_DISP, 0, 0, 1);
        add_row(OP_DISP, 0, 0, 2);
        add_row(OP_WB, 0, 32'h110, 0);
        add_row(OP_WB, 2, 0, 0);
        add_row(OP_IDLE, 3, 0, 8);
        add_row(OP_REG_RD, REG_STATUS, 0, 32'h3);
        add_row(OP_REG_WR, REG_CTRL, 32'h1, 0);
        add_row(OP_IDLE, 2, 0, 11);
        for (int t = 3; t < N_ENTRIES + 1; t++) add_row(OP_DISP, 0, 0, t % N_ENTRIES);
        add_row(OP_WB, 3, 32'h410, 0);
        add_row(OP_WB, 5, 32'h610, 0);
        add_row(OP_WB, 7, 32'h010, 0);               // tag 0 after the wrap
        add_row(OP_IDLE, 2, 0, 17);
        add_row(OP_REG_RD, REG_RETIRED, 0, 17);
        add_row(OP_REG_RD, REG_EXC, 0, 1);
        add_row(OP_REG_RD, REG_STATUS, 0, 32'h100);
    endtask

    initial begin
        row_t row;
        seed            = 32'hce8009f9;
        rst_aL          = 1'b0;
        disp_valid      = 1'b0;
        disp            = '0;
        wb_req          = '0;
        wb_tag          = '0;
        bus_req         = '0;
        retired_cnt     = 0;
        exc_cnt         = 0;
        tail_tag        = '0;
        model_retire_en = 1'b0;
        build_table();
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst_aL = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        check_eq(disp_ready, 1'b1, "disp_ready after reset");
        check_eq(retire.valid, 1'b0, "retire.valid after reset");
        check_eq(bus_rsp.ack, 1'b0, "ack after reset");
        foreach (rows[i]) begin
            row = rows[i];
            case (row.op)
                OP_DISP:   dispatch_one(row.exp);
                OP_WB:     writeback(row.a, row.d);
                OP_REG_WR: reg_write(row.a, row.d);
                OP_REG_RD: reg_read(row.a, row.exp);
                OP_IDLE:   wait_retired(row.exp, row.a);
                default:   ;
            endcase
        end
        if (DUT.u_assertions.fail_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("%0d assertion failures during the run", DUT.u_assertions.fail_cnt);
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
